//--- Bender.yml
package:
  name: decode_stage

sources:
  - rv_dec_pkg.sv
  - instr_decoder.sv
  - reg_file.sv
  - operand_select.sv
  - ex_stage_reg.sv
  - decode_stage.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - decode_stage_chk.sv
      - tb_decode_stage.sv

//--- decode_stage.sv
// RV32I decode and register read stage
`timescale 1ns/1ns

module decode_stage (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  rv_dec_pkg::word_t     instr_i,
    input  rv_dec_pkg::pc_t       pc_i,
    input  rv_dec_pkg::pc_t       pc_next_i,
    input  rv_dec_pkg::word_t     ex_fwd_i,
    input  rv_dec_pkg::wb_t       wb_i,
    input  logic                  stall_i,
    input  logic                  flush_i,
    input  rv_dec_pkg::fwd_e      fwd1_i,
    input  rv_dec_pkg::fwd_e      fwd2_i,
    output rv_dec_pkg::ex_pkt_t   ex_o,
    output rv_dec_pkg::reg_addr_t rs1_addr_o,
    output rv_dec_pkg::reg_addr_t rs2_addr_o
);

    rv_dec_pkg::dec_t  dec;
    rv_dec_pkg::word_t imm;
    rv_dec_pkg::word_t rs1_val;
    rv_dec_pkg::word_t rs2_val;
    rv_dec_pkg::word_t val1;
    rv_dec_pkg::word_t val2;
    rv_dec_pkg::word_t store_data;
    rv_dec_pkg::cmp_t  cmp;

    assign rs1_addr_o = instr_i[19:15];              // To hazard control
    assign rs2_addr_o = instr_i[24:20];

    instr_decoder i_decoder (
        .instr_i (instr_i),
        .dec_o   (dec),
        .imm_o   (imm)
    );

    reg_file i_reg_file (
        .clk_i      (clk_i),
        .rd1_addr_i (rs1_addr_o),
        .rd2_addr_i (rs2_addr_o),
        .rd1_o      (rs1_val),
        .rd2_o      (rs2_val),
        .wb_i       (wb_i)
    );

    operand_select i_operand_select (
        .dec_i        (dec),
        .imm_i        (imm),
        .rs1_i        (rs1_val),
        .rs2_i        (rs2_val),
        .pc_i         (pc_i),
        .fwd1_i       (fwd1_i),
        .fwd2_i       (fwd2_i),
        .ex_fwd_i     (ex_fwd_i),
        .wb_data_i    (wb_i.data),
        .val1_o       (val1),
        .val2_o       (val2),
        .store_data_o (store_data),
        .cmp_o        (cmp)
    );

    ex_stage_reg i_ex_stage_reg (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .stall_i      (stall_i),
        .flush_i      (flush_i),
        .dec_i        (dec),
        .val1_i       (val1),
        .val2_i       (val2),
        .store_data_i (store_data),
        .rd_i         (instr_i[11:7]),
        .pc_next_i    (pc_next_i),
        .cmp_i        (cmp),
        .ex_o         (ex_o)
    );

endmodule

//--- decode_stage_chk.sv
// Decode stage bound assertions
`timescale 1ns/1ns

module decode_stage_chk (
    input logic                clk_i,
    input logic                rst_i,
    input logic                stall_i,
    input logic                flush_i,
    input rv_dec_pkg::ex_pkt_t ex_o
);

    // Reset leaves a bubble in the packet
    a_reset_nop: assert property (@(posedge clk_i)
        rst_i |=> ex_o.dec.op == rv_dec_pkg::OP_NOP)
        else $error("packet op is not NOP after reset");

    a_stall_hold: assert property (@(posedge clk_i)
        !rst_i && stall_i |=> $stable(ex_o))
        else $error("packet changed during stall");

    // Flush wins only when the stage is not stalled
    a_flush_nop: assert property (@(posedge clk_i)
        !rst_i && flush_i && !stall_i |=> ex_o.dec.op == rv_dec_pkg::OP_NOP)
        else $error("packet op is not NOP after flush");

endmodule

//--- ex_stage_reg.sv
// Decode to execute pipeline register
`timescale 1ns/1ns

module ex_stage_reg (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  stall_i,
    input  logic                  flush_i,
    input  rv_dec_pkg::dec_t      dec_i,
    input  rv_dec_pkg::word_t     val1_i,
    input  rv_dec_pkg::word_t     val2_i,
    input  rv_dec_pkg::word_t     store_data_i,
    input  rv_dec_pkg::reg_addr_t rd_i,
    input  rv_dec_pkg::pc_t       pc_next_i,
    input  rv_dec_pkg::cmp_t      cmp_i,
    output rv_dec_pkg::ex_pkt_t   ex_o
);

    rv_dec_pkg::ex_pkt_t pkt_d;

    always_comb begin
        pkt_d = '{dec:        dec_i,
                  val1:       val1_i,
                  val2:       val2_i,
                  store_data: store_data_i,
                  rd:         rd_i,
                  pc_next:    pc_next_i,
                  cmp:        cmp_i};
        if (flush_i) begin
            pkt_d.dec.op = rv_dec_pkg::OP_NOP;       // Bubble while the rest of the packet loads
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ex_o.dec.op <= rv_dec_pkg::OP_NOP;
            ex_o.cmp    <= '0;
        end else if (!stall_i) begin
            ex_o <= pkt_d;
        end
    end

endmodule

//--- instr_decoder.sv
// RV32I instruction decoder
`timescale 1ns/1ns

module instr_decoder (
    input  rv_dec_pkg::word_t instr_i,
    output rv_dec_pkg::dec_t  dec_o,
    output rv_dec_pkg::word_t imm_o
);

    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic              f7_30;
    logic              f7_25;
    rv_dec_pkg::op_e   op_d;
    rv_dec_pkg::opnd_e opnd_d;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign f7_30  = instr_i[30];
    assign f7_25  = instr_i[25];

    // Shared ALU decode for the register and immediate forms
    function automatic rv_dec_pkg::op_e alu_op(input logic [2:0] f3, input logic alt,
                                               input logic m_bit, input logic is_imm);
        rv_dec_pkg::op_e op;
        case (f3)
            3'b000:  op = (alt && !is_imm) ? rv_dec_pkg::OP_SUB : rv_dec_pkg::OP_ADD;
            3'b001:  op = rv_dec_pkg::OP_SLL;
            3'b010:  op = rv_dec_pkg::OP_SLT;
            3'b011:  op = rv_dec_pkg::OP_SLTU;
            3'b100:  op = rv_dec_pkg::OP_XOR;
            3'b101:  op = alt ? rv_dec_pkg::OP_SRA : rv_dec_pkg::OP_SRL;
            3'b110:  op = rv_dec_pkg::OP_OR;
            default: op = rv_dec_pkg::OP_AND;
        endcase
        // Bit 30 is only legal on SUB, SRA, SRAI and as immediate bits
        if (alt && f3 != 3'b101 && (f3 == 3'b001 || (!is_imm && f3 != 3'b000))) begin
            op = rv_dec_pkg::OP_NOP;
        end
        // Bit 25 marks M extension or a bad shift amount
        if (m_bit && (!is_imm || f3[1:0] == 2'b01)) begin
            op = rv_dec_pkg::OP_NOP;
        end
        return op;
    endfunction

    always_comb begin
        op_d   = rv_dec_pkg::OP_NOP;
        opnd_d = rv_dec_pkg::OPND_IMM;
        case (opcode)
            rv_dec_pkg::OPC_OP: begin
                op_d   = alu_op(funct3, f7_30, f7_25, 1'b0);
                opnd_d = rv_dec_pkg::OPND_REG;
            end
            rv_dec_pkg::OPC_OP_IMM: op_d = alu_op(funct3, f7_30, f7_25, 1'b1);
            rv_dec_pkg::OPC_LOAD: begin
                case (funct3)
                    3'b000:  op_d = rv_dec_pkg::OP_LB;
                    3'b001:  op_d = rv_dec_pkg::OP_LH;
                    3'b010:  op_d = rv_dec_pkg::OP_LW;
                    3'b100:  op_d = rv_dec_pkg::OP_LBU;
                    3'b101:  op_d = rv_dec_pkg::OP_LHU;
                    default: op_d = rv_dec_pkg::OP_NOP;
                endcase
            end
            rv_dec_pkg::OPC_STORE: begin
                case (funct3)
                    3'b000:  op_d = rv_dec_pkg::OP_SB;
                    3'b001:  op_d = rv_dec_pkg::OP_SH;
                    3'b010:  op_d = rv_dec_pkg::OP_SW;
                    default: op_d = rv_dec_pkg::OP_NOP;
                endcase
            end
            rv_dec_pkg::OPC_BRANCH: begin
                opnd_d = rv_dec_pkg::OPND_REG;               // Both sources go to the comparator
                case (funct3)
                    3'b000:  op_d = rv_dec_pkg::OP_BEQ;
                    3'b001:  op_d = rv_dec_pkg::OP_BNE;
                    3'b100:  op_d = rv_dec_pkg::OP_BLT;
                    3'b101:  op_d = rv_dec_pkg::OP_BGE;
                    3'b110:  op_d = rv_dec_pkg::OP_BLTU;
                    3'b111:  op_d = rv_dec_pkg::OP_BGEU;
                    default: op_d = rv_dec_pkg::OP_NOP;
                endcase
            end
            rv_dec_pkg::OPC_JALR: begin
                op_d = (funct3 == 3'b000) ? rv_dec_pkg::OP_JALR : rv_dec_pkg::OP_NOP;
            end
            rv_dec_pkg::OPC_LUI: op_d = rv_dec_pkg::OP_LUI;
            rv_dec_pkg::OPC_AUIPC: begin
                op_d   = rv_dec_pkg::OP_AUIPC;
                opnd_d = rv_dec_pkg::OPND_PCIMM;
            end
            rv_dec_pkg::OPC_JAL: begin
                op_d   = rv_dec_pkg::OP_JAL;
                opnd_d = rv_dec_pkg::OPND_PCIMM;
            end
            default: op_d = rv_dec_pkg::OP_NOP;              // FENCE, SYSTEM and unknown
        endcase
        if (op_d == rv_dec_pkg::OP_NOP) begin
            opnd_d = rv_dec_pkg::OPND_REG;
        end
    end

    assign dec_o = '{op: op_d, opnd: opnd_d};

    // Immediate format follows the opcode alone
    always_comb begin
        case (opcode)
            rv_dec_pkg::OPC_LOAD,
            rv_dec_pkg::OPC_OP_IMM,
            rv_dec_pkg::OPC_JALR:   imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
            rv_dec_pkg::OPC_STORE:  imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            rv_dec_pkg::OPC_BRANCH: imm_o = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                                             instr_i[11:8], 1'b0};
            rv_dec_pkg::OPC_JAL:    imm_o = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                                             instr_i[30:21], 1'b0};
            rv_dec_pkg::OPC_LUI,
            rv_dec_pkg::OPC_AUIPC:  imm_o = {instr_i[31:12], 12'b0};
            default:                imm_o = '0;              // R type has no immediate
        endcase
    end

endmodule

//--- operand_select.sv
// Forwarding, operand substitution and branch compare
`timescale 1ns/1ns

module operand_select (
    input  rv_dec_pkg::dec_t  dec_i,
    input  rv_dec_pkg::word_t imm_i,
    input  rv_dec_pkg::word_t rs1_i,
    input  rv_dec_pkg::word_t rs2_i,
    input  rv_dec_pkg::pc_t   pc_i,
    input  rv_dec_pkg::fwd_e  fwd1_i,
    input  rv_dec_pkg::fwd_e  fwd2_i,
    input  rv_dec_pkg::word_t ex_fwd_i,
    input  rv_dec_pkg::word_t wb_data_i,
    output rv_dec_pkg::word_t val1_o,
    output rv_dec_pkg::word_t val2_o,
    output rv_dec_pkg::word_t store_data_o,
    output rv_dec_pkg::cmp_t  cmp_o
);

    rv_dec_pkg::word_t src1;
    rv_dec_pkg::word_t src2;
    rv_dec_pkg::word_t pc_addr;
    logic              use_pc;
    logic              use_imm;

    function automatic rv_dec_pkg::word_t fwd_mux(input rv_dec_pkg::fwd_e sel,
                                                  input rv_dec_pkg::word_t rf_val,
                                                  input rv_dec_pkg::word_t ex_val,
                                                  input rv_dec_pkg::word_t wb_val);
        case (sel)
            rv_dec_pkg::FWD_WB: return wb_val;
            rv_dec_pkg::FWD_EX: return ex_val;
            default:            return rf_val;
        endcase
    endfunction

    assign src1 = fwd_mux(fwd1_i, rs1_i, ex_fwd_i, wb_data_i);
    assign src2 = fwd_mux(fwd2_i, rs2_i, ex_fwd_i, wb_data_i);

    // Compare and store data use the forwarded sources
    assign cmp_o.lt      = $signed(src1) < $signed(src2);
    assign cmp_o.ltu     = src1 < src2;
    assign cmp_o.eq      = src1 == src2;
    assign store_data_o  = src2;

    assign pc_addr = {rv_dec_pkg::PC_TOP, 5'b0, pc_i, 1'b0};   // Byte address of this instruction
    assign use_pc  = dec_i.opnd == rv_dec_pkg::OPND_PC || dec_i.opnd == rv_dec_pkg::OPND_PCIMM;
    assign use_imm = dec_i.opnd == rv_dec_pkg::OPND_IMM || dec_i.opnd == rv_dec_pkg::OPND_PCIMM;

    assign val1_o = use_pc  ? pc_addr : src1;
    assign val2_o = use_imm ? imm_i   : src2;

endmodule

//--- reg_file.sv
// Integer register file
`timescale 1ns/1ns

module reg_file (
    input  logic                  clk_i,
    input  rv_dec_pkg::reg_addr_t rd1_addr_i,
    input  rv_dec_pkg::reg_addr_t rd2_addr_i,
    output rv_dec_pkg::word_t     rd1_o,
    output rv_dec_pkg::word_t     rd2_o,
    input  rv_dec_pkg::wb_t       wb_i
);

    // x0 has no storage
    rv_dec_pkg::word_t regs_q [1:31];

    always_ff @(posedge clk_i) begin
        if (wb_i.we && wb_i.addr != '0) begin
            regs_q[wb_i.addr] <= wb_i.data;
        end
    end

    // Reads see the old value during a write
    assign rd1_o = (rd1_addr_i == '0) ? '0 : regs_q[rd1_addr_i];
    assign rd2_o = (rd2_addr_i == '0) ? '0 : regs_q[rd2_addr_i];

endmodule

//--- rv_dec_pkg.sv
// RV32I decode stage definitions
package rv_dec_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int PC_W       = 18;                  // Half-word PC holding address bits 18:1
    localparam logic [7:0] PC_TOP = 8'h40;           // Fixed upper byte of the code region

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [PC_W-1:0]       pc_t;

    // Major opcodes, instruction bits 6:0
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } rv_opc_e;

    // Operations handed to execute
    typedef enum logic [4:0] {
        OP_NOP,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_JAL, OP_JALR, OP_LUI, OP_AUIPC
    } op_e;

    typedef enum logic [1:0] {
        OPND_REG,                                    // rs1, rs2
        OPND_IMM,                                    // rs1, imm
        OPND_PC,                                     // pc, rs2
        OPND_PCIMM                                   // pc, imm
    } opnd_e;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_EX,
        FWD_WB
    } fwd_e;

    typedef struct packed {
        op_e   op;
        opnd_e opnd;
    } dec_t;

    // Register write from write-back
    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } wb_t;

    typedef struct packed {
        logic lt;                                    // Signed less than
        logic ltu;                                   // Unsigned less than
        logic eq;
    } cmp_t;

    // Packet toward execute
    typedef struct packed {
        dec_t      dec;
        word_t     val1;
        word_t     val2;
        word_t     store_data;
        reg_addr_t rd;
        pc_t       pc_next;                          // Link value for JAL and JALR
        cmp_t      cmp;
    } ex_pkt_t;

endpackage

//--- tb_decode_model.svh
// Decode stage reference model
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

rv_dec_pkg::word_t shadow_regs [0:31];               // x0 stays zero

function automatic rv_dec_pkg::op_e model_alu(input logic [2:0] f3, input logic b30,
                                              input logic b25, input logic is_imm);
    rv_dec_pkg::op_e op;
    case (f3)
        3'b000:  op = (b30 && !is_imm) ? rv_dec_pkg::OP_SUB : rv_dec_pkg::OP_ADD;
        3'b001:  op = rv_dec_pkg::OP_SLL;
        3'b010:  op = rv_dec_pkg::OP_SLT;
        3'b011:  op = rv_dec_pkg::OP_SLTU;
        3'b100:  op = rv_dec_pkg::OP_XOR;
        3'b101:  op = b30 ? rv_dec_pkg::OP_SRA : rv_dec_pkg::OP_SRL;
        3'b110:  op = rv_dec_pkg::OP_OR;
        default: op = rv_dec_pkg::OP_AND;
    endcase
    if (!is_imm && b30 && f3 != 3'b000 && f3 != 3'b101) op = rv_dec_pkg::OP_NOP;
    if (is_imm && b30 && f3 == 3'b001) op = rv_dec_pkg::OP_NOP;
    if (b25 && (!is_imm || f3 == 3'b001 || f3 == 3'b101)) op = rv_dec_pkg::OP_NOP;
    return op;
endfunction

function automatic rv_dec_pkg::dec_t model_dec(input rv_dec_pkg::word_t w);
    rv_dec_pkg::dec_t d;
    logic [2:0]       f3;
    f3     = w[14:12];
    d.op   = rv_dec_pkg::OP_NOP;
    d.opnd = rv_dec_pkg::OPND_IMM;
    case (w[6:0])
        7'b0110011: begin
            d.op   = model_alu(f3, w[30], w[25], 1'b0);
            d.opnd = rv_dec_pkg::OPND_REG;
        end
        7'b0010011: d.op = model_alu(f3, w[30], w[25], 1'b1);
        7'b0000011: begin
            if (f3 == 3'b000) d.op = rv_dec_pkg::OP_LB;
            if (f3 == 3'b001) d.op = rv_dec_pkg::OP_LH;
            if (f3 == 3'b010) d.op = rv_dec_pkg::OP_LW;
            if (f3 == 3'b100) d.op = rv_dec_pkg::OP_LBU;
            if (f3 == 3'b101) d.op = rv_dec_pkg::OP_LHU;
        end
        7'b0100011: begin
            if (f3 == 3'b000) d.op = rv_dec_pkg::OP_SB;
            if (f3 == 3'b001) d.op = rv_dec_pkg::OP_SH;
            if (f3 == 3'b010) d.op = rv_dec_pkg::OP_SW;
        end
        7'b1100011: begin
            d.opnd = rv_dec_pkg::OPND_REG;
            if (f3 == 3'b000) d.op = rv_dec_pkg::OP_BEQ;
            if (f3 == 3'b001) d.op = rv_dec_pkg::OP_BNE;
            if (f3 == 3'b100) d.op = rv_dec_pkg::OP_BLT;
            if (f3 == 3'b101) d.op = rv_dec_pkg::OP_BGE;
            if (f3 == 3'b110) d.op = rv_dec_pkg::OP_BLTU;
            if (f3 == 3'b111) d.op = rv_dec_pkg::OP_BGEU;
        end
        7'b1100111: if (f3 == 3'b000) d.op = rv_dec_pkg::OP_JALR;
        7'b0110111: d.op = rv_dec_pkg::OP_LUI;
        7'b0010111: begin
            d.op   = rv_dec_pkg::OP_AUIPC;
            d.opnd = rv_dec_pkg::OPND_PCIMM;
        end
        7'b1101111: begin
            d.op   = rv_dec_pkg::OP_JAL;
            d.opnd = rv_dec_pkg::OPND_PCIMM;
        end
        default: d.op = rv_dec_pkg::OP_NOP;
    endcase
    if (d.op == rv_dec_pkg::OP_NOP) d.opnd = rv_dec_pkg::OPND_REG;
    return d;
endfunction

function automatic rv_dec_pkg::word_t model_imm(input rv_dec_pkg::word_t w);
    logic s;
    s = w[31];
    case (w[6:0])
        7'b0000011, 7'b0010011, 7'b1100111: return {{20{s}}, w[31:20]};
        7'b0100011: return {{20{s}}, w[31:25], w[11:7]};
        7'b1100011: return {{20{s}}, w[7], w[30:25], w[11:8], 1'b0};
        7'b1101111: return {{12{s}}, w[19:12], w[20], w[30:21], 1'b0};
        7'b0110111, 7'b0010111: return {w[31:12], 12'h000};
        default: return 32'h0;
    endcase
endfunction

function automatic rv_dec_pkg::word_t model_fwd(input rv_dec_pkg::fwd_e f,
        input rv_dec_pkg::word_t rf, input rv_dec_pkg::word_t exf,
        input rv_dec_pkg::word_t wbd);
    if (f == rv_dec_pkg::FWD_WB) return wbd;
    if (f == rv_dec_pkg::FWD_EX) return exf;
    return rf;
endfunction

function automatic rv_dec_pkg::ex_pkt_t model_pkt(input rv_dec_pkg::word_t w,
        input rv_dec_pkg::pc_t pc, input rv_dec_pkg::pc_t pcn, input rv_dec_pkg::word_t exf,
        input rv_dec_pkg::word_t wbd, input rv_dec_pkg::fwd_e f1, input rv_dec_pkg::fwd_e f2,
        input logic flush);
    rv_dec_pkg::ex_pkt_t p;
    rv_dec_pkg::word_t   a;
    rv_dec_pkg::word_t   b;
    a            = model_fwd(f1, shadow_regs[w[19:15]], exf, wbd);
    b            = model_fwd(f2, shadow_regs[w[24:20]], exf, wbd);
    p.dec        = model_dec(w);
    p.cmp.lt     = $signed(a) < $signed(b);
    p.cmp.ltu    = a < b;
    p.cmp.eq     = a == b;
    p.store_data = b;
    p.val1       = (p.dec.opnd == rv_dec_pkg::OPND_PCIMM || p.dec.opnd == rv_dec_pkg::OPND_PC) ?
                   {rv_dec_pkg::PC_TOP, 5'b00000, pc, 1'b0} : a;
    p.val2       = (p.dec.opnd == rv_dec_pkg::OPND_PCIMM || p.dec.opnd == rv_dec_pkg::OPND_IMM) ?
                   model_imm(w) : b;
    p.rd         = w[11:7];
    p.pc_next    = pcn;
    if (flush) p.dec.op = rv_dec_pkg::OP_NOP;
    return p;
endfunction

`endif

//--- tb_decode_stage.sv
// Decode stage testbench
`timescale 1ns/1ns

module tb_decode_stage;

    localparam int TEST_CYCLES = 1100;               // About two cycles per vector plus reset

    logic                  clk_i;
    logic                  rst_i;
    rv_dec_pkg::word_t     instr;
    rv_dec_pkg::pc_t       pc;
    rv_dec_pkg::pc_t       pc_next;
    rv_dec_pkg::word_t     ex_fwd;
    rv_dec_pkg::wb_t       wb;
    logic                  stall;
    logic                  flush;
    rv_dec_pkg::fwd_e      fwd1;
    rv_dec_pkg::fwd_e      fwd2;
    rv_dec_pkg::ex_pkt_t   ex;
    rv_dec_pkg::reg_addr_t rs1_addr;
    rv_dec_pkg::reg_addr_t rs2_addr;
    logic [31:0]           lfsr_q;
    int                    cycles;
    rv_dec_pkg::ex_pkt_t   last_exp;
    rv_dec_pkg::wb_t       w;

    `include "tb_decode_model.svh"

    decode_stage i_dut (
        .clk_i (clk_i), .rst_i (rst_i), .instr_i (instr), .pc_i (pc), .pc_next_i (pc_next),
        .ex_fwd_i (ex_fwd), .wb_i (wb), .stall_i (stall), .flush_i (flush),
        .fwd1_i (fwd1), .fwd2_i (fwd2), .ex_o (ex),
        .rs1_addr_o (rs1_addr), .rs2_addr_o (rs2_addr)
    );

    bind decode_stage decode_stage_chk i_chk (.*);

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= 2 * TEST_CYCLES) begin
            $display("Timeout: the run did not finish within the cycle limit");
            $display(">>> FAIL");
            $fatal(1);
        end
    end

    // Galois LFSR stepped once per bit
    function automatic logic next_bit();
        logic b;
        b      = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (b) lfsr_q = lfsr_q ^ 32'hA300_0000;
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[30:0], next_bit()};
        return v;
    endfunction

    function automatic rv_dec_pkg::fwd_e rand_fwd();
        logic [1:0] v;
        v = 2'(rand_bits(2));
        return (v == 2'd3) ? rv_dec_pkg::FWD_NONE : rv_dec_pkg::fwd_e'(v);
    endfunction

    function automatic rv_dec_pkg::pc_t rand_pc();
        return rv_dec_pkg::pc_t'(rand_bits(rv_dec_pkg::PC_W));
    endfunction

    task automatic check_pkt(input string name, input rv_dec_pkg::ex_pkt_t exp,
                             input rv_dec_pkg::ex_pkt_t act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_dec(input string name, input rv_dec_pkg::dec_t exp,
                             input rv_dec_pkg::dec_t act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_cmp(input string name, input rv_dec_pkg::cmp_t exp,
                             input rv_dec_pkg::cmp_t act);
        if (act !== exp) begin
            $display("ERR %s expected %b actual %b", name, exp, act);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_addr(input string name, input rv_dec_pkg::reg_addr_t exp,
                              input rv_dec_pkg::reg_addr_t act);
        if (act !== exp) begin
            $display("ERR %s expected %0d actual %0d", name, exp, act);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    // Drives one vector at a rising edge and checks it after the next one
    task automatic apply(input string name, input rv_dec_pkg::word_t in, input rv_dec_pkg::pc_t p,
            input rv_dec_pkg::pc_t pn, input rv_dec_pkg::word_t exf, input rv_dec_pkg::wb_t wv,
            input rv_dec_pkg::fwd_e f1, input rv_dec_pkg::fwd_e f2, input logic st,
            input logic fl, input logic chk);
        rv_dec_pkg::ex_pkt_t exp;
        @(posedge clk_i);
        instr   <= in;
        pc      <= p;
        pc_next <= pn;
        ex_fwd  <= exf;
        wb      <= wv;
        fwd1    <= f1;
        fwd2    <= f2;
        stall   <= st;
        flush   <= fl;
        @(negedge clk_i);
        check_addr(name, in[19:15], rs1_addr);
        check_addr(name, in[24:20], rs2_addr);
        exp = st ? last_exp : model_pkt(in, p, pn, exf, wv.data, f1, f2, fl);
        if (wv.we && wv.addr != 5'd0) shadow_regs[wv.addr] = wv.data;
        @(negedge clk_i);
        if (chk) check_pkt(name, exp, ex);
        last_exp = exp;
    endtask

    function automatic rv_dec_pkg::word_t rand_instr(input logic [6:0] opc);
        return {25'(rand_bits(25)), opc};
    endfunction

    initial begin
        logic [6:0]        opcs [0:8];
        rv_dec_pkg::word_t exf;
        opcs = '{7'b0110011, 7'b0010011, 7'b0000011, 7'b0100011, 7'b1100011,
                 7'b1100111, 7'b0110111, 7'b0010111, 7'b1101111};
        clk_i    = 1'b0;
        rst_i    = 1'b1;
        instr    = '0;
        pc       = '0;
        pc_next  = '0;
        ex_fwd   = '0;
        wb       = '0;
        stall    = 1'b0;
        flush    = 1'b0;
        fwd1     = rv_dec_pkg::FWD_NONE;
        fwd2     = rv_dec_pkg::FWD_NONE;
        lfsr_q   = 32'd19;
        cycles   = 0;
        last_exp = '0;
        for (int i = 0; i < 32; i++) shadow_regs[i] = '0;
        repeat (10) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        check_dec("reset", '{op: rv_dec_pkg::OP_NOP, opnd: rv_dec_pkg::OPND_REG},
                  '{op: ex.dec.op, opnd: rv_dec_pkg::OPND_REG});
        check_cmp("reset", 3'b000, ex.cmp);
        for (int a = 1; a < 32; a++) begin
            w = '{we: 1'b1, addr: a[4:0], data: rand_bits(32)};
            apply("reg_write", 32'h0000_0013, '0, '0, '0, w, rv_dec_pkg::FWD_NONE,
                  rv_dec_pkg::FWD_NONE, 1'b0, 1'b0, 1'b0);
        end
        w = '0;
        for (int i = 0; i < 40; i++)
            apply("reg_read", {7'b0, 18'(rand_bits(18)), 7'b0110011}, '0, '0, '0, w,
                  rv_dec_pkg::FWD_NONE, rv_dec_pkg::FWD_NONE, 1'b0, 1'b0, 1'b1);
        for (int i = 0; i < 200; i++) begin
            apply("decode", (i % 5 == 4) ? rand_bits(32) : rand_instr(opcs[rand_bits(32) % 9]),
                  rand_pc(), rand_pc(), '0, w, rv_dec_pkg::FWD_NONE,
                  rv_dec_pkg::FWD_NONE, 1'b0, 1'b0, 1'b1);
        end
        for (int i = 0; i < 50; i++) begin
            w = '{we: 1'b0, addr: '0, data: rand_bits(32)};
            apply("forward", rand_instr(opcs[rand_bits(32) % 9]), rand_pc(), rand_pc(),
                  rand_bits(32), w, rand_fwd(), rand_fwd(), 1'b0, 1'b0, 1'b1);
        end
        for (int i = 0; i < 40; i++)
            apply("pc_operand", rand_instr(rand_bits(1) ? 7'b0010111 : 7'b1101111),
                  rand_pc(), rand_pc(), '0, w, rv_dec_pkg::FWD_NONE,
                  rv_dec_pkg::FWD_NONE, 1'b0, 1'b0, 1'b1);
        for (int i = 0; i < 60; i++) begin
            exf = rand_bits(32);
            w   = '{we: 1'b0, addr: '0, data: rand_bits(2) == 0 ? exf : rand_bits(32)};
            apply("branch", rand_instr(7'b1100011), '0, '0, exf, w, rand_fwd(),
                  rand_fwd(), 1'b0, 1'b0, 1'b1);
        end
        w = '0;
        for (int i = 0; i < 100; i++)
            apply("stall_flush", rand_instr(opcs[rand_bits(32) % 9]), rand_pc(),
                  rand_pc(), rand_bits(32), w, rand_fwd(), rand_fwd(),
                  rand_bits(2) == 0, rand_bits(2) == 0, 1'b1);
        $display(">>> PASS");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+.
rv_dec_pkg.sv
instr_decoder.sv
reg_file.sv
operand_select.sv
ex_stage_reg.sv
decode_stage.sv
decode_stage_chk.sv
tb_decode_stage.sv
